// ==== all.f ====
+incdir+rtl
rtl/mcu_io_pkg.sv
rtl/reg_bus_ctrl.sv
rtl/return_stack.sv
rtl/io_port_regs.sv
rtl/mem_bus_master.sv
rtl/adc_spi_master.sv
rtl/mcu_io_top.sv
tb/tb_mcu_io.sv

// ==== rtl/adc_spi_master.sv ====
`timescale 1ns/10ps
`include "mcu_io_params.svh"

module adc_spi_master import mcu_io_pkg::*; (
    input  logic     sysclk,
    input  logic     reset,
    input  reg_bus_t reg_bus,
    input  logic     adc_miso,
    output logic     adc_cs_n,
    output logic     adc_sclk,
    output logic     adc_mosi,
    output word_t    rd_adc_ctrl,
    output word_t    rd_adc_data
);

    localparam int DIV = `ADC_SCLK_DIV;
    localparam int DW  = $clog2(DIV);

    adc_state_e  state_q;
    logic [3:0]  ctrl_q;
    logic        start_prev_q;
    logic        start_edge;
    logic [DW-1:0] div_cnt_q;
    logic        half_q;
    logic [3:0]  bit_cnt_q;
    logic [15:0] tx_q;
    adc_sample_t rx_q;
    adc_sample_t sample_q;
    logic        half_end;
    logic        busy;

    // bits 2..0 channel, bit 3 start
    always_ff @(posedge sysclk) begin
        if (reset) begin
            ctrl_q       <= '0;
            start_prev_q <= 1'b0;
        end else begin
            if (reg_bus.load[`R_ADC_CTRL]) begin
                ctrl_q <= reg_bus.load_data[3:0];
            end
            start_prev_q <= ctrl_q[3];
        end
    end

    // rising start bit, acted on only when idle
    assign start_edge = ctrl_q[3] && !start_prev_q;

    assign half_end = (div_cnt_q == DW'(DIV - 1));

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state_q   <= ADC_IDLE;
            div_cnt_q <= '0;
            half_q    <= 1'b0;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                ADC_IDLE: begin
                    if (start_edge) begin
                        state_q   <= ADC_SHIFT;
                        div_cnt_q <= '0;
                        half_q    <= 1'b0;
                        bit_cnt_q <= '0;
                    end
                end
                ADC_SHIFT: begin
                    div_cnt_q <= half_end ? '0 : div_cnt_q + 1'b1;
                    if (half_end) begin
                        half_q <= !half_q;
                        // end of high half closes one bit
                        if (half_q) begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == 4'd15) begin
                                state_q <= ADC_DONE;
                            end
                        end
                    end
                end
                default: state_q <= ADC_IDLE;
            endcase
        end
    end

    // command frame loads on start, moves on each falling sclk
    // miso sampled as sclk rises, last 12 bits kept
    always_ff @(posedge sysclk) begin
        if (state_q == ADC_IDLE && start_edge) begin
            tx_q <= {2'b00, ctrl_q[2:0], 11'b0};
        end else if (state_q == ADC_SHIFT && half_end && half_q) begin
            tx_q <= {tx_q[14:0], 1'b0};
        end
        if (state_q == ADC_SHIFT && half_end && !half_q) begin
            rx_q <= {rx_q[10:0], adc_miso};
        end
        if (state_q == ADC_DONE) begin
            sample_q <= rx_q;
        end
    end

    // sclk low in the first half of each bit, idles high
    assign adc_cs_n = (state_q != ADC_SHIFT);
    assign adc_sclk = (state_q != ADC_SHIFT) || half_q;
    assign adc_mosi = (state_q == ADC_SHIFT) && tx_q[15];

    // busy as soon as the edge is seen
    assign busy = (state_q != ADC_IDLE) || start_edge;

    assign rd_adc_ctrl = {12'h000, ctrl_q};
    assign rd_adc_data = {busy, 3'b000, sample_q};

endmodule

// ==== rtl/io_port_regs.sv ====
`timescale 1ns/10ps
`include "mcu_io_params.svh"

module io_port_regs import mcu_io_pkg::*; (
    input  logic       sysclk,
    input  logic       reset,
    input  reg_bus_t   reg_bus,
    input  logic [1:0] keys,
    output logic [7:0] leds,
    output logic [3:0] anmux_ctrl,
    output word_t      rd_leds,
    output word_t      rd_anmux,
    output word_t      rd_keys
);

    logic [7:0] leds_q;
    logic [3:0] anmux_q;
    logic [1:0] keys_meta_q;
    logic [1:0] keys_sync_q;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            leds_q  <= '0;
            anmux_q <= '0;
        end else begin
            if (reg_bus.load[`R_LEDS]) begin
                leds_q <= reg_bus.load_data[7:0];
            end
            // analog mux en, a2, a1, a0
            if (reg_bus.load[`R_ANMUX]) begin
                anmux_q <= reg_bus.load_data[3:0];
            end
        end
    end

    // keys are asynchronous, two-flop sync
    always_ff @(posedge sysclk) begin
        if (reset) begin
            keys_meta_q <= '0;
            keys_sync_q <= '0;
        end else begin
            keys_meta_q <= keys;
            keys_sync_q <= keys_meta_q;
        end
    end

    assign leds       = leds_q;
    assign anmux_ctrl = anmux_q;

    // zero-extended read values
    assign rd_leds  = {8'h00, leds_q};
    assign rd_anmux = {12'h000, anmux_q};
    assign rd_keys  = {14'h0000, keys_sync_q};

endmodule

// ==== rtl/mcu_io_params.svh ====
`ifndef MCU_IO_PARAMS_SVH
`define MCU_IO_PARAMS_SVH

// register indices, apb address bits 5..2

// board i/o
`define R_LEDS           0
`define R_ANMUX          1
`define R_KEYS           2

// hardware return stack, write pushes and read pops
`define R_RSTK           3

// memory bridge, address halves then data
`define R_AV_AD_HI       4
`define R_AV_AD_LO       5
`define R_AV_WRITE_DATA  6
`define R_AV_READ_DATA   7

// adc control and result
`define R_ADC_CTRL       8
`define R_ADC_DATA       9

// highest mapped index
`define TOP_REG          9

// return stack depth in words
`define RSTK_DEPTH       32

// sysclk cycles per spi clock half period
`define ADC_SCLK_DIV     4

`endif

// ==== rtl/mcu_io_pkg.sv ====
`include "mcu_io_params.svh"

package mcu_io_pkg;

    // mcu data word
    typedef logic [15:0] word_t;

    // register index from apb address bits 5..2
    typedef logic [3:0] reg_idx_t;

    // apb byte address, upper bits beyond the index must be zero
    typedef logic [7:0] apb_addr_t;

    // memory bus address, {AV_AD_HI, AV_AD_LO}
    typedef logic [31:0] mem_addr_t;

    // adc result
    typedef logic [11:0] adc_sample_t;

    // one bit per mapped register
    typedef logic [`TOP_REG:0] reg_mask_t;

    // strobes and write data from the apb decoder
    typedef struct packed {
        reg_mask_t load;
        reg_mask_t read;
        word_t     load_data;
    } reg_bus_t;

    // memory bus request, held until waitrequest is low
    typedef struct packed {
        mem_addr_t addr;
        logic      read;
        logic      write;
        word_t     wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WRITE,
        MEM_READ,
        MEM_CAPTURE
    } mem_state_e;

    typedef enum logic [1:0] {
        ADC_IDLE,
        ADC_SHIFT,
        ADC_DONE
    } adc_state_e;

endpackage

// ==== rtl/mcu_io_top.sv ====
`timescale 1ns/10ps

module mcu_io_top import mcu_io_pkg::*; (
    input  logic       sysclk,
    input  logic       reset,
    // apb slave
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    // memory bus master
    output mem_req_t   mem_req,
    input  word_t      mem_rdata,
    input  logic       mem_waitrequest,
    // adc spi
    output logic       adc_cs_n,
    output logic       adc_sclk,
    output logic       adc_mosi,
    input  logic       adc_miso,
    // board i/o
    output logic [7:0] leds,
    output logic [3:0] anmux_ctrl,
    input  logic [1:0] keys
);

    reg_bus_t reg_bus;
    word_t    rd_leds;
    word_t    rd_anmux;
    word_t    rd_keys;
    word_t    rd_rstk;
    word_t    rd_mem;
    word_t    rd_adc_ctrl;
    word_t    rd_adc_data;
    logic     stack_error;
    logic     mem_busy;

    // apb decode, read mux and stall
    reg_bus_ctrl reg_bus_ctrl_inst (
        .sysclk      (sysclk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .rd_leds     (rd_leds),
        .rd_anmux    (rd_anmux),
        .rd_keys     (rd_keys),
        .rd_rstk     (rd_rstk),
        .rd_mem      (rd_mem),
        .rd_adc_ctrl (rd_adc_ctrl),
        .rd_adc_data (rd_adc_data),
        .stack_error (stack_error),
        .mem_busy    (mem_busy),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .reg_bus     (reg_bus)
    );

    return_stack return_stack_inst (
        .sysclk   (sysclk),
        .reset    (reset),
        .reg_bus  (reg_bus),
        .top_word (rd_rstk),
        .error    (stack_error)
    );

    io_port_regs io_port_regs_inst (
        .sysclk     (sysclk),
        .reset      (reset),
        .reg_bus    (reg_bus),
        .keys       (keys),
        .leds       (leds),
        .anmux_ctrl (anmux_ctrl),
        .rd_leds    (rd_leds),
        .rd_anmux   (rd_anmux),
        .rd_keys    (rd_keys)
    );

    mem_bus_master mem_bus_master_inst (
        .sysclk          (sysclk),
        .reset           (reset),
        .reg_bus         (reg_bus),
        .mem_rdata       (mem_rdata),
        .mem_waitrequest (mem_waitrequest),
        .mem_req         (mem_req),
        .rd_mem          (rd_mem),
        .busy            (mem_busy)
    );

    adc_spi_master adc_spi_master_inst (
        .sysclk      (sysclk),
        .reset       (reset),
        .reg_bus     (reg_bus),
        .adc_miso    (adc_miso),
        .adc_cs_n    (adc_cs_n),
        .adc_sclk    (adc_sclk),
        .adc_mosi    (adc_mosi),
        .rd_adc_ctrl (rd_adc_ctrl),
        .rd_adc_data (rd_adc_data)
    );

endmodule

// ==== rtl/mem_bus_master.sv ====
`timescale 1ns/10ps
`include "mcu_io_params.svh"

module mem_bus_master import mcu_io_pkg::*; (
    input  logic     sysclk,
    input  logic     reset,
    input  reg_bus_t reg_bus,
    input  word_t    mem_rdata,
    input  logic     mem_waitrequest,
    output mem_req_t mem_req,
    output word_t    rd_mem,
    output logic     busy
);

    mem_state_e state_q;
    word_t      ad_hi_q;
    word_t      ad_lo_q;
    word_t      wdata_q;
    word_t      rdata_q;
    logic       start_write;
    logic       start_read;
    logic       read_done;

    // the write data register triggers both directions
    // software sets the address first and touches write data last
    assign start_write = reg_bus.load[`R_AV_WRITE_DATA];
    assign start_read  = reg_bus.read[`R_AV_WRITE_DATA];

    // read data valid in the cycle waitrequest drops
    assign read_done = (state_q == MEM_READ) && !mem_waitrequest;

    always_ff @(posedge sysclk) begin
        if (reg_bus.load[`R_AV_AD_HI]) begin
            ad_hi_q <= reg_bus.load_data;
        end
        if (reg_bus.load[`R_AV_AD_LO]) begin
            ad_lo_q <= reg_bus.load_data;
        end
        if (start_write) begin
            wdata_q <= reg_bus.load_data;
        end
        if (read_done) begin
            rdata_q <= mem_rdata;
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state_q <= MEM_IDLE;
        end else begin
            case (state_q)
                MEM_IDLE: begin
                    if (start_write) begin
                        state_q <= MEM_WRITE;
                    end else if (start_read) begin
                        state_q <= MEM_READ;
                    end
                end
                MEM_WRITE: begin
                    if (!mem_waitrequest) begin
                        state_q <= MEM_IDLE;
                    end
                end
                MEM_READ: begin
                    if (!mem_waitrequest) begin
                        state_q <= MEM_CAPTURE;
                    end
                end
                // extra cycle so read data settles before the next access
                default: state_q <= MEM_IDLE;
            endcase
        end
    end

    always_comb begin
        mem_req.addr  = {ad_hi_q, ad_lo_q};
        mem_req.read  = (state_q == MEM_READ);
        mem_req.write = (state_q == MEM_WRITE);
        mem_req.wdata = wdata_q;
    end

    // stalls the apb side through request and capture
    assign busy = (state_q != MEM_IDLE);

    // read strobes are one-hot, so and-or picks the register
    assign rd_mem = ({16{reg_bus.read[`R_AV_AD_HI]}} & ad_hi_q)
                  | ({16{reg_bus.read[`R_AV_AD_LO]}} & ad_lo_q)
                  | ({16{reg_bus.read[`R_AV_WRITE_DATA]}} & wdata_q)
                  | ({16{reg_bus.read[`R_AV_READ_DATA]}} & rdata_q);

endmodule

// ==== rtl/reg_bus_ctrl.sv ====
`timescale 1ns/10ps
`include "mcu_io_params.svh"

module reg_bus_ctrl import mcu_io_pkg::*; (
    input  logic      sysclk,
    input  logic      reset,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  word_t     pwdata,
    input  word_t     rd_leds,
    input  word_t     rd_anmux,
    input  word_t     rd_keys,
    input  word_t     rd_rstk,
    input  word_t     rd_mem,
    input  word_t     rd_adc_ctrl,
    input  word_t     rd_adc_data,
    input  logic      stack_error,
    input  logic      mem_busy,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr,
    output reg_bus_t  reg_bus
);

    // writes to these are dropped without error
    localparam reg_mask_t RO_MASK = reg_mask_t'((1 << `R_KEYS)
                                               | (1 << `R_AV_READ_DATA)
                                               | (1 << `R_ADC_DATA));

    reg_idx_t  idx;
    logic      mapped;
    logic      access;
    logic      acc_done_q;
    reg_mask_t sel;

    assign idx = paddr[5:2];

    // unmapped if above top register or outside the 64-byte window
    assign mapped = (paddr[7:6] == 2'b00) && (idx <= reg_idx_t'(`TOP_REG));

    // access phase completes unless the memory bridge is still busy
    assign access = psel && penable && !acc_done_q && !mem_busy;

    assign sel = mapped ? (reg_mask_t'(1) << idx) : '0;

    // strobes live only in the completing cycle
    assign reg_bus.load      = (access && pwrite) ? (sel & ~RO_MASK) : '0;
    assign reg_bus.read      = (access && !pwrite) ? sel : '0;
    assign reg_bus.load_data = pwdata;

    assign pready  = access;
    assign pslverr = access && (!mapped || stack_error);

    // one strobe per access, even if penable is held past pready
    always_ff @(posedge sysclk) begin
        if (reset) begin
            acc_done_q <= 1'b0;
        end else begin
            acc_done_q <= psel && penable && (acc_done_q || access);
        end
    end

    // read mux by index
    // bridge registers share one return word
    always_comb begin
        case (idx)
            `R_LEDS:          prdata = rd_leds;
            `R_ANMUX:         prdata = rd_anmux;
            `R_KEYS:          prdata = rd_keys;
            `R_RSTK:          prdata = rd_rstk;
            `R_AV_AD_HI,
            `R_AV_AD_LO,
            `R_AV_WRITE_DATA,
            `R_AV_READ_DATA:  prdata = rd_mem;
            `R_ADC_CTRL:      prdata = rd_adc_ctrl;
            `R_ADC_DATA:      prdata = rd_adc_data;
            default:          prdata = '0;
        endcase
    end

endmodule

// ==== rtl/return_stack.sv ====
`timescale 1ns/10ps
`include "mcu_io_params.svh"

module return_stack import mcu_io_pkg::*; (
    input  logic     sysclk,
    input  logic     reset,
    input  reg_bus_t reg_bus,
    output word_t    top_word,
    output logic     error
);

    localparam int DEPTH = `RSTK_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    // pointer counts entries, 0 to DEPTH
    logic [AW:0]   ptr_q;
    logic [AW-1:0] top_idx;
    logic          push;
    logic          pop;
    logic          full;
    logic          empty;
    word_t         stack_mem [DEPTH];

    assign push  = reg_bus.load[`R_RSTK];
    assign pop   = reg_bus.read[`R_RSTK];
    assign full  = (ptr_q == (AW+1)'(DEPTH));
    assign empty = (ptr_q == '0);

    // wraps to the last slot when full
    assign top_idx = ptr_q[AW-1:0] - AW'(1);

    // empty stack pops as zero
    assign top_word = empty ? '0 : stack_mem[top_idx];

    // overflow or underflow on this strobe
    assign error = (push && full) || (pop && empty);

    always_ff @(posedge sysclk) begin
        if (push && !full) begin
            stack_mem[ptr_q[AW-1:0]] <= reg_bus.load_data;
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            ptr_q <= '0;
        end else if (push && !full) begin
            ptr_q <= ptr_q + 1'b1;
        end else if (pop && !empty) begin
            ptr_q <= ptr_q - 1'b1;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_mcu_io -f all.f -o tb_mcu_io

./obj_dir/tb_mcu_io > sim.log 2>&1 || true
cat sim.log

if grep -qF "All tests passed!" sim.log; then
    exit 0
else
    exit 1
fi

// ==== tb/tb_mcu_io.sv ====
`timescale 1ns/10ps
`include "mcu_io_params.svh"

module tb_mcu_io import mcu_io_pkg::*; ();

    localparam logic [31:0] SEED = 32'h35c8_cdfb;
    localparam int PREADY_TIMEOUT = 64;
    localparam int POLL_LIMIT     = 100;
    localparam int FRAME_CYCLES   = 16 * 2 * `ADC_SCLK_DIV;
    localparam int HOLD_WAITS     = 5;

    logic       sysclk;
    logic       reset;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    word_t      pwdata;
    word_t      prdata;
    logic       pready;
    logic       pslverr;
    mem_req_t   mem_req;
    word_t      mem_rdata = '0;
    logic       mem_waitrequest = 1'b0;
    logic       adc_cs_n;
    logic       adc_sclk;
    logic       adc_mosi;
    logic       adc_miso = 1'b0;
    logic [7:0] leds;
    logic [3:0] anmux_ctrl;
    logic [1:0] keys;

    // separate lfsr streams for stimulus and memory wait states
    logic [31:0] stim_lfsr = SEED;
    logic [31:0] wait_lfsr = SEED;
    int          last_stalls;

    // memory slave state
    // forced_waits below 0 means random wait states
    int          forced_waits = -1;
    int          wait_left = 0;
    int          reads_done = 0;
    mem_addr_t   exp_addr = '0;
    word_t       exp_wdata = '0;
    word_t       mem_model [65536];

    // adc model state
    logic        sclk_seen = 1'b1;
    logic        cs_seen = 1'b1;
    int          adc_bit = 0;
    logic [2:0]  adc_chan = '0;
    logic [15:0] mosi_word = '0;
    int          cs_low_cycles = 0;
    logic [15:0] last_cmd = '0;
    int          last_low = 0;
    int          frames_done = 0;

    mcu_io_top mcu_io_top_inst (
        .sysclk          (sysclk),
        .reset           (reset),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .mem_req         (mem_req),
        .mem_rdata       (mem_rdata),
        .mem_waitrequest (mem_waitrequest),
        .adc_cs_n        (adc_cs_n),
        .adc_sclk        (adc_sclk),
        .adc_mosi        (adc_mosi),
        .adc_miso        (adc_miso),
        .leds            (leds),
        .anmux_ctrl      (anmux_ctrl),
        .keys            (keys)
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    task automatic value_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen in time", what);
        $display("Test failures found");
        $fatal(1, "run stopped on timeout");
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    // one step per bit taken
    function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int nbits);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < nbits; i++) begin
            fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            bits  = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // adc transfer function of the model
    function automatic logic [11:0] adc_value(input logic [2:0] ch);
        return 12'h0A5 + 12'h111 * {9'b0, ch};
    endfunction

    // setup phase then access phase until pready
    // pready and read data sampled on the falling edge
    task automatic apb_access(input logic write, input int idx, input word_t wdata,
                              output word_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge sysclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= apb_addr_t'(idx << 2);
        pwdata  <= wdata;
        @(posedge sysclk);
        penable <= 1'b1;
        @(negedge sysclk);
        while (!pready) begin
            if (waited >= PREADY_TIMEOUT) begin
                report_timeout("pready on apb access");
            end
            waited++;
            @(negedge sysclk);
        end
        rdata       = prdata;
        err         = pslverr;
        last_stalls = waited;
        @(posedge sysclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input int idx, input word_t data, output logic err);
        word_t unused;
        apb_access(1'b1, idx, data, unused, err);
    endtask

    task automatic reg_read(input int idx, output word_t data, output logic err);
        apb_access(1'b0, idx, '0, data, err);
    endtask

    // memory slave model sees the request of the cycle that just ended
    always @(posedge sysclk) begin : mem_slave
        int w;
        w = (forced_waits >= 0) ? forced_waits : int'(lfsr_take(wait_lfsr, 2));
        if (mem_req.write || mem_req.read) begin
            assert (mem_req.addr == exp_addr)
                else value_error($sformatf("mem addr %h, expected %h", mem_req.addr, exp_addr));
            if (mem_req.write) begin
                assert (mem_req.wdata == exp_wdata)
                    else value_error($sformatf("mem wdata %h, expected %h",
                                               mem_req.wdata, exp_wdata));
            end
            if (!mem_waitrequest) begin
                if (mem_req.write) begin
                    mem_model[mem_req.addr[15:0]] <= mem_req.wdata;
                end
                if (mem_req.read) begin
                    reads_done <= reads_done + 1;
                end
                wait_left       <= w;
                mem_waitrequest <= (w != 0);
            end else begin
                wait_left       <= wait_left - 1;
                mem_waitrequest <= (wait_left > 1);
            end
        end else begin
            // wait states for the next request picked ahead while idle
            wait_left       <= w;
            mem_waitrequest <= (w != 0);
        end
        mem_rdata <= mem_model[mem_req.addr[15:0]];
    end

    // adc model acts one sysclk after each falling sclk
    always @(posedge sysclk) begin : adc_model
        logic [15:0] cmd;
        logic [2:0]  ch;
        logic [11:0] value;
        if (adc_cs_n) begin
            // frame just closed
            if (!cs_seen) begin
                last_cmd    <= mosi_word;
                last_low    <= cs_low_cycles;
                frames_done <= frames_done + 1;
            end
            adc_bit       <= 0;
            mosi_word     <= '0;
            cs_low_cycles <= 0;
            adc_miso      <= 1'b0;
        end else begin
            cs_low_cycles <= cs_low_cycles + 1;
            if (sclk_seen && !adc_sclk) begin
                cmd = {mosi_word[14:0], adc_mosi};
                // channel bits 13..11 are frame bits 2..4
                ch = (adc_bit == 4) ? cmd[2:0] : adc_chan;
                value = adc_value(ch);
                mosi_word <= cmd;
                adc_chan  <= ch;
                adc_bit   <= adc_bit + 1;
                // 4 leading zeros then the sample msb first
                adc_miso  <= (adc_bit >= 4) ? value[15 - adc_bit] : 1'b0;
            end
        end
        sclk_seen <= adc_sclk;
        cs_seen   <= adc_cs_n;
    end

    initial begin : stimulus
        word_t     rdata;
        word_t     leds_val;
        word_t     anmux_val;
        logic      err;
        word_t     stack_vals [`RSTK_DEPTH];
        mem_addr_t addrs [8];
        word_t     datas [8];
        int        polls;
        int        frames_before;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        keys    = 2'b00;
        reset   = 1'b1;
        repeat (16) @(posedge sysclk);
        reset <= 1'b0;
        @(negedge sysclk);
        assert (!pready && !pslverr && !mem_req.read && !mem_req.write)
            else value_error("apb or memory request not idle after reset");
        assert (adc_cs_n && adc_sclk) else value_error("spi cs_n or sclk not high after reset");

        // board i/o ports follow on the cycle after the access
        leds_val = word_t'(lfsr_take(stim_lfsr, 16));
        reg_write(`R_LEDS, leds_val, err);
        @(negedge sysclk);
        assert (leds == leds_val[7:0]) else value_error($sformatf("leds port %h", leds));
        reg_read(`R_LEDS, rdata, err);
        assert (rdata == {8'h00, leds_val[7:0]} && !err)
            else value_error($sformatf("leds read %h", rdata));
        anmux_val = word_t'(lfsr_take(stim_lfsr, 16));
        reg_write(`R_ANMUX, anmux_val, err);
        @(negedge sysclk);
        assert (anmux_ctrl == anmux_val[3:0])
            else value_error($sformatf("anmux port %h", anmux_ctrl));
        reg_read(`R_ANMUX, rdata, err);
        assert (rdata == {12'h000, anmux_val[3:0]})
            else value_error($sformatf("anmux read %h", rdata));
        for (int k = 1; k < 4; k++) begin
            @(posedge sysclk);
            keys <= 2'(k);
            reg_read(`R_KEYS, rdata, err);
            assert (rdata == word_t'(k)) else value_error($sformatf("keys read %h", rdata));
        end
        // write to read-only keys dropped without error
        reg_write(`R_KEYS, 16'hffff, err);
        assert (!err) else value_error("pslverr on write to keys");
        reg_read(`R_KEYS, rdata, err);
        assert (rdata == 16'h0003 && !err) else value_error("write to keys not ignored");

        // fill the return stack past full then drain it past empty
        for (int i = 0; i < `RSTK_DEPTH; i++) begin
            stack_vals[i] = word_t'(lfsr_take(stim_lfsr, 16));
            reg_write(`R_RSTK, stack_vals[i], err);
            assert (!err) else value_error($sformatf("pslverr on push %0d", i));
        end
        reg_write(`R_RSTK, 16'hdead, err);
        assert (err) else value_error("no pslverr on stack overflow");
        for (int i = `RSTK_DEPTH - 1; i >= 0; i--) begin
            reg_read(`R_RSTK, rdata, err);
            assert (rdata == stack_vals[i] && !err)
                else value_error($sformatf("pop %h, expected %h", rdata, stack_vals[i]));
        end
        reg_read(`R_RSTK, rdata, err);
        assert (err && rdata == '0) else value_error("stack underflow not flagged as 0");
        reg_read(12, rdata, err);
        assert (err) else value_error("no pslverr on index 12");

        // memory writes to random addresses with distinct low bits
        for (int i = 0; i < 8; i++) begin
            addrs[i] = {16'(lfsr_take(stim_lfsr, 16)), 12'(lfsr_take(stim_lfsr, 12)), 4'(i)};
            datas[i] = word_t'(lfsr_take(stim_lfsr, 16));
            reg_write(`R_AV_AD_HI, addrs[i][31:16], err);
            reg_write(`R_AV_AD_LO, addrs[i][15:0], err);
            exp_addr  = addrs[i];
            exp_wdata = datas[i];
            reg_write(`R_AV_WRITE_DATA, datas[i], err);
        end
        for (int i = 0; i < 8; i++) begin
            reg_write(`R_AV_AD_HI, addrs[i][31:16], err);
            reg_write(`R_AV_AD_LO, addrs[i][15:0], err);
            exp_addr = addrs[i];
            reg_read(`R_AV_WRITE_DATA, rdata, err);
            assert (rdata == datas[7]) else value_error($sformatf("write data reg %h", rdata));
            reg_read(`R_AV_READ_DATA, rdata, err);
            assert (rdata == datas[i] && !err)
                else value_error($sformatf("mem read %h, expected %h", rdata, datas[i]));
            assert (reads_done == i + 1)
                else value_error($sformatf("%0d memory reads seen, expected %0d",
                                           reads_done, i + 1));
        end

        // under back-pressure the next access phase opens 2 cycles into the request
        reg_write(`R_AV_AD_HI, addrs[1][31:16], err);
        reg_write(`R_AV_AD_LO, addrs[1][15:0], err);
        exp_addr     = addrs[1];
        exp_wdata    = datas[1];
        forced_waits = HOLD_WAITS;
        reg_write(`R_AV_WRITE_DATA, datas[1], err);
        reg_read(`R_LEDS, rdata, err);
        assert (last_stalls == HOLD_WAITS + 1 - 2 && rdata == {8'h00, leds_val[7:0]})
            else value_error($sformatf("held after write %0d cycles, read %h",
                                       last_stalls, rdata));
        reg_write(`R_AV_AD_HI, addrs[0][31:16], err);
        reg_write(`R_AV_AD_LO, addrs[0][15:0], err);
        exp_addr = addrs[0];
        reg_read(`R_AV_WRITE_DATA, rdata, err);
        // read adds the capture cycle
        reg_read(`R_AV_READ_DATA, rdata, err);
        assert (last_stalls == HOLD_WAITS + 2 - 2 && rdata == datas[0])
            else value_error($sformatf("held after read %0d cycles, read %h",
                                       last_stalls, rdata));
        forced_waits = -1;

        // adc conversion on every channel
        for (int ch = 0; ch < 8; ch++) begin
            frames_before = frames_done;
            reg_write(`R_ADC_CTRL, word_t'(ch), err);
            reg_write(`R_ADC_CTRL, word_t'(ch) | 16'h0008, err);
            reg_read(`R_ADC_DATA, rdata, err);
            @(negedge sysclk);
            assert (rdata[15] && !adc_cs_n) else value_error("adc not busy after start");
            polls = 0;
            while (rdata[15]) begin
                if (polls >= POLL_LIMIT) begin
                    report_timeout("adc busy clear");
                end
                polls++;
                reg_read(`R_ADC_DATA, rdata, err);
            end
            assert (frames_done == frames_before + 1 && last_low == FRAME_CYCLES)
                else value_error($sformatf("frame %0d cycles long", last_low));
            assert (last_cmd == {2'b00, 3'(ch), 11'b0})
                else value_error($sformatf("mosi command %h", last_cmd));
            assert (rdata == {4'h0, adc_value(3'(ch))})
                else value_error($sformatf("adc data %h on channel %0d", rdata, ch));
        end

        $display("All tests passed!");
        $finish;
    end

endmodule
